/* msc_bot.f */
+incdir+common
common/msc_bot_pkg.sv
cbw/cbw_parser.sv
csw/csw_gen.sv
source/axis_skid.sv
source/msc_bot_top.sv
verification/msc_bot_tb.sv

/* Makefile */
SIM = obj_dir/Vmsc_bot_tb

all: run

build:
	verilator --binary --timing --timescale 1ns/100ps -f msc_bot.f \
	  --top-module msc_bot_tb -o Vmsc_bot_tb

run: build
	./$(SIM) | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f msc_bot.f \
	  --top-module msc_bot_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* verification/msc_bot_tb.sv */
`include "msc_bot_params.svh"

module msc_bot_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import msc_bot_pkg::*;

  localparam int NUM_TESTS   = 48;
  localparam int MAX_DATA    = 20;
  // Worst case per test with gapped CBW, stalled data, SCSI delay, stalled CSW and drain
  localparam int TEST_CYCLES = 31 * 2 + MAX_DATA * 2 + 16 + 13 * 2 + 20;
  localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES * 4;

  logic        clock = 1'b0;
  logic        reset;
  logic        enable_i;
  logic        error_i;
  logic        bulk_tvalid_i;
  logic        bulk_tready_o;
  logic        bulk_tlast_i;
  logic [7:0]  bulk_tdata_i;
  logic        dat_tvalid_i;
  logic        dat_tready_o;
  logic        dat_tlast_i;
  logic [7:0]  dat_tdata_i;
  logic        usb_tvalid_o;
  logic        usb_tready_i;
  logic        usb_tlast_o;
  logic [7:0]  usb_tdata_o;
  logic        cmd_vld_o;
  logic        cmd_dir_o;
  logic [31:0] cmd_len_o;
  logic [3:0]  cmd_lun_o;
  logic [7:0]  cmd_op_o;
  logic        scsi_done_i;
  logic        scsi_fail_i;

  int          seed    = 32'h5866;
  int          bp_seed = 32'h5866 + 1;  // Separate stream for back-pressure
  int          errors  = 0;
  int          checks  = 0;
  int          cycles  = 0;
  logic [7:0]  cbw_buf [0:31];
  logic [9:0]  exp_q[$];  // {is_status, last, data}

  msc_bot_top DUT (
    .clock         (clock),
    .reset         (reset),
    .enable_i      (enable_i),
    .error_i       (error_i),
    .bulk_tvalid_i (bulk_tvalid_i),
    .bulk_tready_o (bulk_tready_o),
    .bulk_tlast_i  (bulk_tlast_i),
    .bulk_tdata_i  (bulk_tdata_i),
    .dat_tvalid_i  (dat_tvalid_i),
    .dat_tready_o  (dat_tready_o),
    .dat_tlast_i   (dat_tlast_i),
    .dat_tdata_i   (dat_tdata_i),
    .usb_tvalid_o  (usb_tvalid_o),
    .usb_tready_i  (usb_tready_i),
    .usb_tlast_o   (usb_tlast_o),
    .usb_tdata_o   (usb_tdata_o),
    .cmd_vld_o     (cmd_vld_o),
    .cmd_dir_o     (cmd_dir_o),
    .cmd_len_o     (cmd_len_o),
    .cmd_lun_o     (cmd_lun_o),
    .cmd_op_o      (cmd_op_o),
    .scsi_done_i   (scsi_done_i),
    .scsi_fail_i   (scsi_fail_i)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    return int'(rand_word() % 32'(n));
  endfunction

  task automatic check_byte(input logic [7:0] exp_data, input logic exp_last,
                            input logic [7:0] act_data, input logic act_last);
    checks++;
    if (act_data !== exp_data) begin
      $display("FAIL %0t usb_tdata_o expected %h actual %h", $time, exp_data, act_data);
      errors++;
    end
    if (act_last !== exp_last) begin
      $display("FAIL %0t usb_tlast_o expected %b actual %b", $time, exp_last, act_last);
      errors++;
    end
  endtask

  task automatic check_status(input csw_status_e exp_st, input csw_status_e act_st);
    checks++;
    if (act_st !== exp_st) begin
      $display("FAIL %0t csw_status expected %0d actual %0d", $time, exp_st, act_st);
      errors++;
    end
  endtask

  task automatic check_cmd(input logic exp_vld, input logic exp_dir,
                           input logic [31:0] exp_len, input logic [3:0] exp_lun,
                           input logic [7:0] exp_op);
    checks++;
    if (cmd_vld_o !== exp_vld) begin
      $display("FAIL %0t cmd_vld_o expected %b actual %b", $time, exp_vld, cmd_vld_o);
      errors++;
    end
    // Bulk-out is drained while idle and stalled while a command is held
    if (bulk_tready_o !== ~exp_vld) begin
      $display("FAIL %0t bulk_tready_o expected %b actual %b", $time, ~exp_vld,
               bulk_tready_o);
      errors++;
    end
    if (exp_vld && cmd_dir_o !== exp_dir) begin
      $display("FAIL %0t cmd_dir_o expected %b actual %b", $time, exp_dir, cmd_dir_o);
      errors++;
    end
    if (exp_vld && cmd_len_o !== exp_len) begin
      $display("FAIL %0t cmd_len_o expected %h actual %h", $time, exp_len, cmd_len_o);
      errors++;
    end
    if (exp_vld && cmd_lun_o !== exp_lun) begin
      $display("FAIL %0t cmd_lun_o expected %h actual %h", $time, exp_lun, cmd_lun_o);
      errors++;
    end
    if (exp_vld && cmd_op_o !== exp_op) begin
      $display("FAIL %0t cmd_op_o expected %h actual %h", $time, exp_op, cmd_op_o);
      errors++;
    end
  endtask

  // Pops the model on every bulk-in handshake
  task automatic monitor_bulk_in();
    logic [9:0] entry;
    forever begin
      @(posedge clock);
      if (usb_tvalid_o && usb_tready_i) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected bulk-in byte %h at %0t, none was due", usb_tdata_o, $time);
          errors++;
        end else begin
          entry = exp_q.pop_front();
          check_byte(entry[7:0], entry[8], usb_tdata_o, usb_tlast_o);
          if (entry[9]) begin
            check_status(csw_status_e'(entry[7:0]), csw_status_e'(usb_tdata_o));
          end
        end
      end
    end
  endtask

  task automatic drive_backpressure();
    logic [31:0] r;
    forever begin
      @(negedge clock);
      r = $random(bp_seed);
      usb_tready_i = (r[1:0] != 2'b00);  // Ready three cycles in four
      enable_i     = (r[3:2] != 2'b00);
    end
  endtask

  task automatic build_cbw(input logic bad_sig, input logic [31:0] tag, input logic [31:0] len,
                           input logic dir, input logic [3:0] lun, input logic [7:0] op);
    le_dword_u sig;
    le_dword_u tag_w;
    le_dword_u len_w;
    int        flip;
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
      r = rand_word();
      cbw_buf[i] = r[7:0];  // Random CDB filler
    end
    sig.word   = `MSC_CBW_SIG;
    tag_w.word = tag;
    len_w.word = len;
    if (bad_sig) begin
      flip = rand_below(32);
      sig.word[flip] = ~sig.word[flip];
    end
    for (int i = 0; i < 4; i++) begin
      cbw_buf[i]     = sig.bytes[i];
      cbw_buf[i + 4] = tag_w.bytes[i];
      cbw_buf[i + 8] = len_w.bytes[i];
    end
    cbw_buf[12] = {dir, 7'b0};
    cbw_buf[13] = {4'b0, lun};
    cbw_buf[14] = 8'(1 + rand_below(16));  // CDB length
    cbw_buf[15] = op;
  endtask

  // Host side of the bulk-out pipe with random idle gaps
  task automatic send_bulk(input int nbytes);
    for (int i = 0; i < nbytes; i++) begin
      @(negedge clock);
      while (rand_below(4) == 0) begin
        bulk_tvalid_i = 1'b0;
        @(negedge clock);
      end
      bulk_tvalid_i = 1'b1;
      bulk_tdata_i  = cbw_buf[i];
      bulk_tlast_i  = (i == nbytes - 1);
      @(posedge clock);
      while (!bulk_tready_o) @(posedge clock);
    end
    @(negedge clock);
    bulk_tvalid_i = 1'b0;
    bulk_tlast_i  = 1'b0;
  endtask

  task automatic send_data(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      @(negedge clock);
      r = rand_word();
      dat_tvalid_i = 1'b1;
      dat_tdata_i  = r[7:0];
      dat_tlast_i  = (i == n - 1);
      exp_q.push_back({1'b0, dat_tlast_i, r[7:0]});
      @(posedge clock);
      while (!dat_tready_o) @(posedge clock);
    end
    @(negedge clock);
    dat_tvalid_i = 1'b0;
    dat_tlast_i  = 1'b0;
  endtask

  task automatic pulse_scsi(input logic fail, input logic err);
    @(negedge clock);
    scsi_done_i = ~fail;
    scsi_fail_i = fail;
    error_i     = err;
    @(negedge clock);
    scsi_done_i = 1'b0;
    scsi_fail_i = 1'b0;
    error_i     = 1'b0;
  endtask

  task automatic report_test(input int idx, input string kind, input int err_before);
    $display("test %0d %s: %s", idx, kind, (errors == err_before) ? "ok" : "errors");
  endtask

  task automatic run_good(input int idx, input logic dir, input logic fail, input logic err,
                          input string kind);
    le_dword_u   sig;
    le_dword_u   tag;
    le_dword_u   len;
    le_dword_u   residue;
    logic [31:0] r;
    int          n;
    int          err_before;
    csw_status_e st;
    err_before = errors;
    tag.word   = rand_word();
    r          = rand_word();
    len.word   = dir ? 32'(rand_below(MAX_DATA * 2)) : rand_word();
    build_cbw(1'b0, tag.word, len.word, dir, r[3:0], r[15:8]);
    send_bulk(`MSC_CBW_BYTES);
    while (!cmd_vld_o) @(negedge clock);
    check_cmd(1'b1, dir, len.word, r[3:0], r[15:8]);
    n = 0;
    if (dir) begin
      n = rand_below(((len.word > MAX_DATA) ? MAX_DATA : int'(len.word)) + 1);
      send_data(n);
    end
    repeat (rand_below(8)) @(negedge clock);
    sig.word     = `MSC_CSW_SIG;
    residue.word = len.word - 32'(n);
    st = err ? CSW_PHASE : (fail ? CSW_FAILED : CSW_GOOD);
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back({2'b00, sig.bytes[i]});
    end
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back({2'b00, tag.bytes[i]});
    end
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back({2'b00, residue.bytes[i]});
    end
    exp_q.push_back({2'b11, st});
    pulse_scsi(fail, err);
    while (exp_q.size() != 0 || cmd_vld_o) @(negedge clock);  // Drained and released
    report_test(idx, kind, err_before);
  endtask

  task automatic run_bad(input int idx, input logic bad_sig, input string kind);
    logic [31:0] r;
    int          nbytes;
    int          err_before;
    err_before = errors;
    r = rand_word();
    build_cbw(bad_sig, rand_word(), rand_word(), r[0], r[7:4], r[15:8]);
    nbytes = bad_sig ? `MSC_CBW_BYTES : (r[16] ? 30 : 32);
    send_bulk(nbytes);
    repeat (4) @(negedge clock);
    check_cmd(1'b0, 1'b0, 32'h0, 4'h0, 8'h0);
    pulse_scsi(r[17], 1'b0);
    repeat (16) @(negedge clock);  // Window for any stray bulk-in byte
    check_cmd(1'b0, 1'b0, 32'h0, 4'h0, 8'h0);
    report_test(idx, kind, err_before);
  endtask

  initial begin
    logic [31:0] r;
    reset         = 1'b1;
    enable_i      = 1'b1;
    error_i       = 1'b0;
    bulk_tvalid_i = 1'b0;
    bulk_tlast_i  = 1'b0;
    bulk_tdata_i  = 8'h00;
    dat_tvalid_i  = 1'b0;
    dat_tlast_i   = 1'b0;
    dat_tdata_i   = 8'h00;
    usb_tready_i  = 1'b1;
    scsi_done_i   = 1'b0;
    scsi_fail_i   = 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    fork
      monitor_bulk_in();
      drive_backpressure();
    join_none
    run_good(0, 1'b0, 1'b0, 1'b0, "out done");
    run_good(1, 1'b1, 1'b0, 1'b0, "in done");
    run_good(2, 1'b1, 1'b1, 1'b0, "in fail");
    run_good(3, 1'b0, 1'b0, 1'b1, "out phase error");
    run_good(4, 1'b1, 1'b1, 1'b1, "in fail phase error");
    run_bad(5, 1'b1, "bad signature");
    run_good(6, 1'b0, 1'b0, 1'b0, "out done after bad signature");
    run_bad(7, 1'b0, "bad length");
    run_good(8, 1'b1, 1'b0, 1'b0, "in done after bad length");
    for (int i = 9; i < NUM_TESTS; i++) begin
      r = rand_word();
      if (r[3:0] == 4'd0) begin
        run_bad(i, 1'b1, "random bad signature");
      end else if (r[3:0] == 4'd1) begin
        run_bad(i, 1'b0, "random bad length");
      end else begin
        run_good(i, r[4], r[5], (r[7:6] == 2'b00), "random");
      end
    end
    repeat (8) @(negedge clock);
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* source/msc_bot_top.sv */
module msc_bot_top (
  input  logic        clock,
  input  logic        reset,

  input  logic        enable_i,
  input  logic        error_i,

  // Host bulk-out pipe
  input  logic        bulk_tvalid_i,
  output logic        bulk_tready_o,
  input  logic        bulk_tlast_i,
  input  logic [7:0]  bulk_tdata_i,

  // Target data, device to host
  input  logic        dat_tvalid_i,
  output logic        dat_tready_o,
  input  logic        dat_tlast_i,
  input  logic [7:0]  dat_tdata_i,

  // Bulk-in pipe
  output logic        usb_tvalid_o,
  input  logic        usb_tready_i,
  output logic        usb_tlast_o,
  output logic [7:0]  usb_tdata_o,

  // SCSI controller side
  output logic        cmd_vld_o,
  output logic        cmd_dir_o,
  output logic [31:0] cmd_len_o,
  output logic [3:0]  cmd_lun_o,
  output logic [7:0]  cmd_op_o,
  input  logic        scsi_done_i,
  input  logic        scsi_fail_i
);

  import msc_bot_pkg::*;

  logic        cbw_vld;
  logic        cbw_dir;
  le_dword_u   cbw_tag;
  logic [31:0] cbw_len;
  logic [3:0]  cbw_lun;
  logic [7:0]  cbw_op;
  logic        csw_sent;

  logic        skid_valid;
  logic        skid_ready;
  logic        skid_last;
  logic [7:0]  skid_data;

  cbw_parser u_parser (
    .clock         (clock),
    .reset         (reset),
    .bulk_tvalid_i (bulk_tvalid_i),
    .bulk_tready_o (bulk_tready_o),
    .bulk_tlast_i  (bulk_tlast_i),
    .bulk_tdata_i  (bulk_tdata_i),
    .csw_sent_i    (csw_sent),
    .cbw_vld_o     (cbw_vld),
    .cbw_dir_o     (cbw_dir),
    .cbw_tag_o     (cbw_tag),
    .cbw_len_o     (cbw_len),
    .cbw_lun_o     (cbw_lun),
    .cbw_op_o      (cbw_op)
  );

  csw_gen u_csw (
    .clock        (clock),
    .reset        (reset),
    .enable_i     (enable_i),
    .error_i      (error_i),
    .scsi_done_i  (scsi_done_i),
    .scsi_fail_i  (scsi_fail_i),
    .cbw_vld_i    (cbw_vld),
    .cbw_dir_i    (cbw_dir),
    .cbw_tag_i    (cbw_tag),
    .cbw_len_i    (cbw_len),
    .dat_tvalid_i (dat_tvalid_i),
    .dat_tready_o (dat_tready_o),
    .dat_tlast_i  (dat_tlast_i),
    .dat_tdata_i  (dat_tdata_i),
    .skid_valid_o (skid_valid),
    .skid_ready_i (skid_ready),
    .skid_last_o  (skid_last),
    .skid_data_o  (skid_data),
    .csw_sent_o   (csw_sent)
  );

  axis_skid #(
    .WIDTH (8)
  ) u_skid (
    .clock      (clock),
    .reset      (reset),
    .s_tvalid_i (skid_valid),
    .s_tready_o (skid_ready),
    .s_tlast_i  (skid_last),
    .s_tdata_i  (skid_data),
    .m_tvalid_o (usb_tvalid_o),
    .m_tready_i (usb_tready_i),
    .m_tlast_o  (usb_tlast_o),
    .m_tdata_o  (usb_tdata_o)
  );

  // Held command straight to the SCSI side
  assign cmd_vld_o = cbw_vld;
  assign cmd_dir_o = cbw_dir;
  assign cmd_len_o = cbw_len;
  assign cmd_lun_o = cbw_lun;
  assign cmd_op_o  = cbw_op;

endmodule

/* source/axis_skid.sv */
module axis_skid #(
  parameter int WIDTH = 8
) (
  input  logic             clock,
  input  logic             reset,

  input  logic             s_tvalid_i,
  output logic             s_tready_o,
  input  logic             s_tlast_i,
  input  logic [WIDTH-1:0] s_tdata_i,

  output logic             m_tvalid_o,
  input  logic             m_tready_i,
  output logic             m_tlast_o,
  output logic [WIDTH-1:0] m_tdata_o
);

  logic             out_vld;
  logic             out_last;
  logic [WIDTH-1:0] out_data;
  logic             spare_vld;
  logic             spare_last;
  logic [WIDTH-1:0] spare_data;
  logic             in_rdy;

  logic             in_hs;
  logic             out_free;
  logic             take_spare;
  logic             take_input;
  logic             fill_spare;
  logic             spare_next;

  assign in_hs      = s_tvalid_i & in_rdy;
  assign out_free   = ~spare_vld & (~out_vld | m_tready_i);
  assign take_spare = spare_vld & m_tready_i;  // Spare moves up as output drains
  assign take_input = out_free & in_hs;
  assign fill_spare = ~spare_vld & out_vld & ~m_tready_i & in_hs;

  assign spare_next = take_spare ? 1'b0 : (fill_spare | spare_vld);

  always_ff @(posedge clock) begin
    if (reset) begin
      out_vld   <= 1'b0;
      spare_vld <= 1'b0;
      in_rdy    <= 1'b0;  // Comes up the cycle after reset
    end else begin
      if (out_free) begin
        out_vld <= in_hs;
      end
      spare_vld <= spare_next;
      in_rdy    <= ~spare_next;  // Registered, drops only with both entries full
    end
  end

  always_ff @(posedge clock) begin
    if (take_spare) begin
      out_data <= spare_data;
      out_last <= spare_last;
    end else if (take_input) begin
      out_data <= s_tdata_i;
      out_last <= s_tlast_i;
    end
    if (fill_spare) begin
      spare_data <= s_tdata_i;
      spare_last <= s_tlast_i;
    end
  end

  assign s_tready_o = in_rdy;
  assign m_tvalid_o = out_vld;
  assign m_tlast_o  = out_last;
  assign m_tdata_o  = out_data;

endmodule

/* csw/csw_gen.sv */
`include "msc_bot_params.svh"

module csw_gen (
  input  logic                   clock,
  input  logic                   reset,

  input  logic                   enable_i,
  input  logic                   error_i,

  // SCSI controller strobes
  input  logic                   scsi_done_i,
  input  logic                   scsi_fail_i,

  // Command from the parser
  input  logic                   cbw_vld_i,
  input  logic                   cbw_dir_i,
  input  msc_bot_pkg::le_dword_u cbw_tag_i,
  input  logic [31:0]            cbw_len_i,

  // Target data, device to host
  input  logic                   dat_tvalid_i,
  output logic                   dat_tready_o,
  input  logic                   dat_tlast_i,
  input  logic [7:0]             dat_tdata_i,

  // Into the skid buffer
  output logic                   skid_valid_o,
  input  logic                   skid_ready_i,
  output logic                   skid_last_o,
  output logic [7:0]             skid_data_o,

  output logic                   csw_sent_o
);

  import msc_bot_pkg::*;

  // One state per CSW byte, in wire order from ST_SIG0 to ST_STAT
  localparam logic [3:0] ST_IDLE = 4'd0;
  localparam logic [3:0] ST_PASS = 4'd1;
  localparam logic [3:0] ST_SIG0 = 4'd2;
  localparam logic [3:0] ST_TAG0 = ST_SIG0 + 4'd4;
  localparam logic [3:0] ST_RES0 = ST_TAG0 + 4'd4;
  localparam logic [3:0] ST_STAT = ST_SIG0 + 4'(`MSC_CSW_BYTES - 1);

  logic [3:0]  state;
  logic [3:0]  pos;
  logic [31:0] count;
  logic [31:0] count_now;
  logic        in_pass;
  logic        in_csw;
  logic        start;
  logic        dat_hs;
  logic        csw_hs;
  logic [7:0]  csw_byte;

  le_dword_u   csw_sig;
  le_dword_u   residue;
  csw_status_e status;

  assign csw_sig = `MSC_CSW_SIG;

  assign in_pass = (state == ST_PASS);
  assign in_csw  = (state >= ST_SIG0);

  // Done and fail are single-cycle pulses, caught from idle or pass-through
  assign start = cbw_vld_i & (scsi_done_i | scsi_fail_i) & (state <= ST_PASS);

  assign dat_hs    = in_pass & dat_tvalid_i & skid_ready_i;
  assign count_now = count + 32'(dat_hs);  // Includes a byte taken alongside the pulse

  // A status byte is only offered while enabled
  assign csw_hs     = in_csw & enable_i & skid_ready_i;
  assign csw_sent_o = csw_hs & (state == ST_STAT);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          count <= '0;
          if (start) begin
            state <= ST_SIG0;
          end else if (cbw_vld_i && cbw_dir_i) begin
            state <= ST_PASS;  // IN transfer, open the data path
          end
        end
        ST_PASS: begin
          count <= count_now;
          if (start) begin
            state <= ST_SIG0;
          end else if (!cbw_vld_i) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          if (csw_hs) begin
            state <= (state == ST_STAT) ? ST_IDLE : state + 4'd1;
          end
        end
      endcase
    end
  end

  // Outcome of the command, frozen when the status phase begins
  always_ff @(posedge clock) begin
    if (start) begin
      residue <= cbw_len_i - count_now;
      if (error_i) begin
        status <= CSW_PHASE;
      end else if (scsi_fail_i) begin
        status <= CSW_FAILED;
      end else begin
        status <= CSW_GOOD;
      end
    end
  end

  // Byte within the CSW, low two bits pick the byte of a field
  assign pos = state - ST_SIG0;

  always_comb begin
    if (state < ST_TAG0) begin
      csw_byte = csw_sig.bytes[pos[1:0]];
    end else if (state < ST_RES0) begin
      csw_byte = cbw_tag_i.bytes[pos[1:0]];
    end else if (state < ST_STAT) begin
      csw_byte = residue.bytes[pos[1:0]];
    end else begin
      csw_byte = status;
    end
  end

  // Data path is shared between target data and status
  assign dat_tready_o = in_pass & skid_ready_i;
  assign skid_valid_o = in_pass ? dat_tvalid_i : (in_csw & enable_i);
  assign skid_last_o  = in_pass ? dat_tlast_i : (state == ST_STAT);
  assign skid_data_o  = in_pass ? dat_tdata_i : csw_byte;

endmodule

/* cbw/cbw_parser.sv */
`include "msc_bot_params.svh"

module cbw_parser (
  input  logic                   clock,
  input  logic                   reset,

  // Host bulk-out stream
  input  logic                   bulk_tvalid_i,
  output logic                   bulk_tready_o,
  input  logic                   bulk_tlast_i,
  input  logic [7:0]             bulk_tdata_i,

  // Release from the status side
  input  logic                   csw_sent_i,

  // Decoded command, held until the CSW is out
  output logic                   cbw_vld_o,
  output logic                   cbw_dir_o,
  output msc_bot_pkg::le_dword_u cbw_tag_o,
  output logic [31:0]            cbw_len_o,
  output logic [3:0]             cbw_lun_o,
  output logic [7:0]             cbw_op_o
);

  import msc_bot_pkg::*;

  // Byte offsets inside the CBW
  localparam logic [5:0] OFS_FLAGS = 6'd12;
  localparam logic [5:0] OFS_LUN   = 6'd13;
  localparam logic [5:0] OFS_CDB0  = 6'd15;
  localparam logic [5:0] LAST_IDX  = 6'(`MSC_CBW_BYTES - 1);

  logic [5:0] byte_cnt;
  logic       held;
  logic       bulk_hs;
  logic       good;

  le_dword_u  sig;
  le_dword_u  tag;
  le_dword_u  len;
  logic       dir;
  logic [3:0] lun;
  logic [7:0] op;

  // Drain everything while no command is pending
  assign bulk_tready_o = ~held;
  assign bulk_hs       = bulk_tvalid_i & ~held;

  // Signature is complete long before the last byte arrives
  assign good = (sig.word == `MSC_CBW_SIG) && (byte_cnt == LAST_IDX);

  always_ff @(posedge clock) begin
    if (reset) begin
      byte_cnt <= '0;
      held     <= 1'b0;
    end else if (held) begin
      if (csw_sent_i) begin
        held <= 1'b0;
      end
    end else if (bulk_hs) begin
      if (bulk_tlast_i) begin
        byte_cnt <= '0;
        held     <= good;  // Malformed wrappers vanish here
      end else if (byte_cnt != '1) begin
        byte_cnt <= byte_cnt + 6'd1;  // Saturates on long packets
      end
    end
  end

  // Field capture, bytes land in place as they go by
  always_ff @(posedge clock) begin
    if (bulk_hs) begin
      case (byte_cnt)
        6'd0, 6'd1, 6'd2, 6'd3:   sig.bytes[byte_cnt[1:0]] <= bulk_tdata_i;
        6'd4, 6'd5, 6'd6, 6'd7:   tag.bytes[byte_cnt[1:0]] <= bulk_tdata_i;
        6'd8, 6'd9, 6'd10, 6'd11: len.bytes[byte_cnt[1:0]] <= bulk_tdata_i;
        OFS_FLAGS: dir <= bulk_tdata_i[7];    // Set means device to host
        OFS_LUN:   lun <= bulk_tdata_i[3:0];
        OFS_CDB0:  op  <= bulk_tdata_i;       // Operation code only
        default: ;
      endcase
    end
  end

  assign cbw_vld_o = held;
  assign cbw_dir_o = dir;
  assign cbw_tag_o = tag;
  assign cbw_len_o = len.word;
  assign cbw_lun_o = lun;
  assign cbw_op_o  = op;

endmodule

/* common/msc_bot_pkg.sv */
package msc_bot_pkg;

  // Status byte of the CSW
  typedef enum logic [7:0] {
    CSW_GOOD   = 8'd0,
    CSW_FAILED = 8'd1,
    CSW_PHASE  = 8'd2  // Phase error
  } csw_status_e;

  // Bulk-only wrapper fields go over the wire least significant byte first,
  // bytes[0] is the first byte on the bus
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } le_dword_u;

endpackage

/* common/msc_bot_params.svh */
`ifndef MSC_BOT_PARAMS_SVH
`define MSC_BOT_PARAMS_SVH

// Wrapper signatures, "USBC" and "USBS" as little-endian words
`define MSC_CBW_SIG 32'h43425355
`define MSC_CSW_SIG 32'h53425355

// Wrapper lengths in bytes
`define MSC_CBW_BYTES 31
`define MSC_CSW_BYTES 13

`endif
